/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_invaders_display
RTL_TOP    := invaders_display
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only when the pass line shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* filelist.f */
+incdir+include
verilog/invaders_pkg.sv
verilog/screen_mode_ctrl.sv
verilog/alien_formation.sv
verilog/spaceship_ctrl.sv
verilog/pixel_compositor.sv
verilog/invaders_display.sv
tests/tb_invaders_display.sv

/* include/invaders_cfg.svh */
`ifndef INVADERS_CFG_SVH
`define INVADERS_CFG_SVH

//////////////////////////////////////////////////////////////////////
// screen size
`define SCREEN_W 640
`define SCREEN_H 480

//////////////////////////////////////////////////////////////////////
// separation border rows
`define SCOREBOARD_TOP 0
`define SCOREBOARD_BOTTOM 40
`define BARRIER_TOP 340
`define BARRIER_BOTTOM 400
`define EXTRA_LIVES_TOP 460

//////////////////////////////////////////////////////////////////////
// alien grid, origin is the top left corner of alien 0
`define ALIEN_ROWS 5
`define ALIEN_COLS 11
`define ALIEN_W 20
`define ALIEN_H 16
`define ALIEN_PITCH_X 50
`define ALIEN_PITCH_Y 30
`define ALIEN_START_X 70
`define ALIEN_START_Y 88
`define ALIEN_STEP 10
`define ALIEN_DROP 10
`define EDGE_MARGIN 10

// player ship
`define SHIP_W 40
`define SHIP_H 16
`define SHIP_Y 420
`define SHIP_START_X 300
`define SHIP_STEP 4

// start screen band
`define BANNER_TOP 200
`define BANNER_BOTTOM 280

//////////////////////////////////////////////////////////////////////
// colours, packed as blue 2 | green 3 | red 3
`define COLOR_SHIP 8'h78
`define COLOR_ALIEN 8'hAA
`define COLOR_BANNER 8'hFF
`define COLOR_SPACE 8'h00
`define COLOR_RED 8'h07
`define COLOR_BLUE 8'hC0
`define COLOR_GREEN 8'h38

`endif

/* tests/tb_invaders_display.sv */
`include "invaders_cfg.svh"

module tb_invaders_display;
	timeunit 1ns;
	timeprecision 1ps;
	import invaders_pkg::*;

	// formation width from origin to the right edge of the last column
	localparam int SPAN_W = (`ALIEN_COLS - 1) * `ALIEN_PITCH_X + `ALIEN_W;
	localparam int WAIT_LIMIT = 20;

	logic   clk;
	logic   rst;
	logic   button_left;
	logic   button_right;
	logic   button_display;
	coord_t x;
	coord_t y;
	color_t rgb;

	int          errors;
	int          checks;
	logic [31:0] rng_state;

	// reference model state
	screen_mode_e m_mode;
	int           m_ox;
	int           m_oy;
	logic         m_dir_right;
	int           m_ship;

	invaders_display u_invaders_display (
		.clk            (clk),
		.rst            (rst),
		.button_left    (button_left),
		.button_right   (button_right),
		.button_display (button_display),
		.x              (x),
		.y              (y),
		.rgb            (rgb)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// reference model

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic int rand_below(input int n);
		rng_state = xorshift32(rng_state);
		return int'(rng_state % n);
	endfunction

	// box test over every alien of the grid
	function automatic logic alien_hit(input int px, input int py);
		logic hit;
		int   r;
		int   c;
		int   bx;
		int   by;
		hit = 1'b0;
		for (r = 0; r < `ALIEN_ROWS; r++) begin
			for (c = 0; c < `ALIEN_COLS; c++) begin
				bx = m_ox + c * `ALIEN_PITCH_X;
				by = m_oy + r * `ALIEN_PITCH_Y;
				if (px >= bx && px < bx + `ALIEN_W && py >= by && py < by + `ALIEN_H)
					hit = 1'b1;
			end
		end
		return hit;
	endfunction

	function automatic color_t expect_color(input int px, input int py);
		if (px >= `SCREEN_W || py >= `SCREEN_H || m_mode == mode_black)
			return `COLOR_SPACE;
		if (m_mode == mode_start)
			return (py >= `BANNER_TOP && py < `BANNER_BOTTOM) ? `COLOR_BANNER : `COLOR_SPACE;
		if (py == `SCOREBOARD_TOP || py == `SCOREBOARD_BOTTOM)
			return `COLOR_RED;
		if (py == `BARRIER_TOP || py == `BARRIER_BOTTOM)
			return `COLOR_BLUE;
		if (py == `EXTRA_LIVES_TOP)
			return `COLOR_GREEN;
		if (px >= m_ship && px < m_ship + `SHIP_W && py >= `SHIP_Y && py < `SHIP_Y + `SHIP_H)
			return `COLOR_SHIP;
		if (alien_hit(px, py))
			return `COLOR_ALIEN;
		return `COLOR_SPACE;
	endfunction

	task automatic reset_formation();
		m_ox = `ALIEN_START_X;
		m_oy = `ALIEN_START_Y;
		m_dir_right = 1'b1;
	endtask

	// one game-mode frame end with march then ship
	task automatic step_model();
		logic edge_hit;
		if (m_mode == mode_game) begin
			if (m_dir_right)
				edge_hit = (m_ox + `ALIEN_STEP + SPAN_W > `SCREEN_W - `EDGE_MARGIN);
			else
				edge_hit = (m_ox - `ALIEN_STEP < `EDGE_MARGIN);
			if (edge_hit) begin
				m_oy = m_oy + `ALIEN_DROP;
				m_dir_right = ~m_dir_right;
			end else begin
				m_ox = m_dir_right ? m_ox + `ALIEN_STEP : m_ox - `ALIEN_STEP;
			end
			if (button_right && !button_left)
				m_ship = (m_ship + `SHIP_STEP > `SCREEN_W - `SHIP_W) ?
					`SCREEN_W - `SHIP_W : m_ship + `SHIP_STEP;
			else if (button_left && !button_right)
				m_ship = (m_ship < `SHIP_STEP) ? 0 : m_ship - `SHIP_STEP;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus and checks

	// pixel in and one edge of latency before the falling-edge sample
	task automatic check_pixel(input int px, input int py);
		color_t exp;
		exp = expect_color(px, py);
		@(posedge clk);
		x <= coord_t'(px);
		y <= coord_t'(py);
		@(posedge clk);
		@(negedge clk);
		checks++;
		assert (rgb === exp) else begin
			errors++;
			$display("mismatch at %0d ns: rgb got 8'h%02h expected 8'h%02h at (%0d,%0d)",
				$time, rgb, exp, px, py);
		end
	endtask

	task automatic wait_color(input int px, input int py, input color_t exp, input string what);
		int   n;
		logic seen;
		n = 0;
		seen = 1'b0;
		while (!seen && n < WAIT_LIMIT) begin
			@(posedge clk);
			x <= coord_t'(px);
			y <= coord_t'(py);
			@(posedge clk);
			@(negedge clk);
			seen = (rgb === exp);
			n++;
		end
		checks++;
		assert (seen) else begin
			errors++;
			$display("timed out at %0d ns waiting for the %s screen", $time, what);
		end
	endtask

	// press the display button for hold cycles
	task automatic advance_mode(input int hold);
		@(posedge clk);
		button_display <= 1'b1;
		repeat (hold) @(posedge clk);
		button_display <= 1'b0;
		case (m_mode)
			mode_black: m_mode = mode_start;
			mode_start: m_mode = mode_game;
			default:    m_mode = mode_black;
		endcase
		if (m_mode != mode_game)
			reset_formation();
		case (m_mode)
			mode_start: wait_color(320, 240, `COLOR_BANNER, "start");
			mode_game:  wait_color(320, `SCOREBOARD_BOTTOM, `COLOR_RED, "game");
			default:    wait_color(320, `SCOREBOARD_BOTTOM, `COLOR_SPACE, "black");
		endcase
	endtask

	task automatic frame_end_cycle();
		@(posedge clk);
		x <= coord_t'(`SCREEN_W - 1);
		y <= coord_t'(`SCREEN_H - 1);
		@(posedge clk);
		x <= '0;
		y <= '0;
		step_model();
	endtask

	task automatic set_buttons(input logic left, input logic right);
		@(posedge clk);
		button_left <= left;
		button_right <= right;
	endtask

	// rows stay clear of the last pixel so no stray frame end
	task automatic probe_random(input int count, input int y_base, input int y_span);
		repeat (count) check_pixel(rand_below(`SCREEN_W), y_base + rand_below(y_span));
	endtask

	task automatic check_ship();
		check_pixel(m_ship, `SHIP_Y);
		check_pixel(m_ship + `SHIP_W - 1, `SHIP_Y + `SHIP_H - 1);
		check_pixel(m_ship + `SHIP_W, `SHIP_Y);
		check_pixel(m_ship, `BARRIER_BOTTOM);
		check_pixel(m_ship, `SHIP_Y + `SHIP_H);
		if (m_ship > 0)
			check_pixel(m_ship - 1, `SHIP_Y + 5);
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests

	task automatic blank_after_reset();
		probe_random(20, 0, `SCREEN_H - 1);
	endtask

	task automatic mode_cycle();
		advance_mode(1);
		check_pixel(320, `BANNER_TOP - 1);
		check_pixel(320, `BANNER_TOP);
		check_pixel(639, `BANNER_BOTTOM - 1);
		check_pixel(320, `BANNER_BOTTOM);
		advance_mode(1);
		check_pixel(100, `SCOREBOARD_TOP);
		check_pixel(100, `BARRIER_TOP);
		check_pixel(100, `BARRIER_BOTTOM);
		check_pixel(100, `EXTRA_LIVES_TOP);
		check_pixel(5, `SCOREBOARD_BOTTOM + 1);
		advance_mode(1);
		check_pixel(100, `BARRIER_TOP);
		// a long press still gives only the start screen
		advance_mode(6);
		check_pixel(320, 240);
		check_pixel(320, `SCOREBOARD_BOTTOM);
		advance_mode(1);
	endtask

	task automatic formation_drawing();
		check_pixel(70, 88);
		check_pixel(570, 208);
		check_pixel(589, 223);
		check_pixel(90, 88);
		check_pixel(115, 95);
		check_pixel(70, 104);
		check_pixel(70, 238);
	endtask

	// long enough to turn at both sides
	task automatic march_frames();
		repeat (20) begin
			frame_end_cycle();
			check_pixel(m_ox, m_oy);
			check_pixel(m_ox + SPAN_W - 1, m_oy + 4 * `ALIEN_PITCH_Y + `ALIEN_H - 1);
			probe_random(4, 80, 200);
		end
	endtask

	task automatic ship_movement();
		int n;
		check_ship();
		set_buttons(1'b0, 1'b1);
		repeat (3) begin
			frame_end_cycle();
			check_ship();
		end
		set_buttons(1'b1, 1'b1);
		repeat (2) frame_end_cycle();
		check_ship();
		set_buttons(1'b1, 1'b0);
		n = 0;
		while (m_ship > 0 && n < 100) begin
			frame_end_cycle();
			n++;
		end
		repeat (3) frame_end_cycle();
		check_ship();
		set_buttons(1'b0, 1'b0);
	endtask

	task automatic rejoin_game();
		advance_mode(1);
		advance_mode(1);
		advance_mode(1);
		check_pixel(70, 88);
		check_pixel(570, 208);
		probe_random(6, 80, 200);
		check_ship();
	endtask

	initial begin
		errors = 0;
		checks = 0;
		rng_state = 32'hc33e;
		m_mode = mode_black;
		m_ship = `SHIP_START_X;
		reset_formation();
		rst <= 1'b1;
		button_left <= 1'b0;
		button_right <= 1'b0;
		button_display <= 1'b0;
		x <= '0;
		y <= '0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		blank_after_reset();
		mode_cycle();
		formation_drawing();
		march_frames();
		ship_movement();
		rejoin_game();
		$display("errors: %0d in %0d checks", errors, checks);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* verilog/alien_formation.sv */
`include "invaders_cfg.svh"

module alien_formation (
	input  logic                       clk,
	input  logic                       rst,
	input  invaders_pkg::screen_mode_e mode,
	input  logic                       frame_end,
	input  invaders_pkg::coord_t       x,
	input  invaders_pkg::coord_t       y,
	output logic                       on_alien
);
	import invaders_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// geometry in coordinate width
	localparam coord_t START_X = coord_t'(`ALIEN_START_X);
	localparam coord_t START_Y = coord_t'(`ALIEN_START_Y);
	localparam coord_t STEP = coord_t'(`ALIEN_STEP);
	localparam coord_t DROP = coord_t'(`ALIEN_DROP);
	localparam coord_t PITCH_X = coord_t'(`ALIEN_PITCH_X);
	localparam coord_t PITCH_Y = coord_t'(`ALIEN_PITCH_Y);
	localparam coord_t BOX_W = coord_t'(`ALIEN_W);
	localparam coord_t BOX_H = coord_t'(`ALIEN_H);
	localparam coord_t COLS = coord_t'(`ALIEN_COLS);
	localparam coord_t ROWS = coord_t'(`ALIEN_ROWS);

	// origin x to right edge of the last column
	localparam coord_t SPAN_W = coord_t'((`ALIEN_COLS - 1) * `ALIEN_PITCH_X + `ALIEN_W);
	localparam coord_t RIGHT_LIMIT = coord_t'(`SCREEN_W - `EDGE_MARGIN);
	// a left step from below this would cross the margin
	localparam coord_t LEFT_LIMIT = coord_t'(`EDGE_MARGIN + `ALIEN_STEP);
	localparam coord_t MIN_X = coord_t'(`EDGE_MARGIN);
	localparam coord_t MAX_X = coord_t'(`SCREEN_W - `EDGE_MARGIN - SPAN_W);
	localparam coord_t LAST_ROW = coord_t'(`SCREEN_H);

	coord_t origin_x;
	coord_t origin_y;
	logic   dir_right;

	coord_t right_next;
	logic   at_edge;

	// pixel position relative to the grid
	coord_t dx;
	coord_t dy;
	coord_t col;
	coord_t row;
	coord_t cell_x;
	coord_t cell_y;
	logic   in_grid;

	//////////////////////////////////////////////////////////////////////
	// march

	assign right_next = origin_x + STEP + SPAN_W;
	assign at_edge = dir_right ? (right_next > RIGHT_LIMIT) : (origin_x < LEFT_LIMIT);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			origin_x <= START_X;
			origin_y <= START_Y;
			dir_right <= 1'b1;
		end else if (mode != mode_game) begin
			// parked until the game starts
			origin_x <= START_X;
			origin_y <= START_Y;
			dir_right <= 1'b1;
		end else if (frame_end) begin
			if (at_edge) begin
				// drop a row and turn, no sideways move this frame
				origin_y <= origin_y + DROP;
				dir_right <= ~dir_right;
			end else if (dir_right) begin
				origin_x <= origin_x + STEP;
			end else begin
				origin_x <= origin_x - STEP;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// hit test for the current pixel

	assign dx = x - origin_x;
	assign dy = y - origin_y;
	assign col = dx / PITCH_X;
	assign row = dy / PITCH_Y;
	assign cell_x = dx % PITCH_X;
	assign cell_y = dy % PITCH_Y;

	// offsets wrap when the pixel is above or left of the origin
	assign in_grid = (x >= origin_x) && (y >= origin_y) && (col < COLS) && (row < ROWS);

	assign on_alien = in_grid && (cell_x < BOX_W) && (cell_y < BOX_H);

	//////////////////////////////////////////////////////////////////////
	// checks

	a_origin_on_screen: assert property (@(posedge clk) disable iff (rst)
		(frame_end && mode == mode_game) |=>
			(origin_x >= MIN_X) && (origin_x <= MAX_X) && (origin_y < LAST_ROW));

endmodule

/* verilog/invaders_display.sv */
`include "invaders_cfg.svh"

module invaders_display (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 button_left,
	input  logic                 button_right,
	input  logic                 button_display,
	input  invaders_pkg::coord_t x,
	input  invaders_pkg::coord_t y,
	output invaders_pkg::color_t rgb
);
	import invaders_pkg::*;

	// last visible pixel of the frame
	localparam coord_t LAST_X = coord_t'(`SCREEN_W - 1);
	localparam coord_t LAST_Y = coord_t'(`SCREEN_H - 1);

	screen_mode_e mode;
	logic         frame_end;
	logic         on_alien;
	logic         on_ship;

	// objects step once per frame, here
	assign frame_end = (x == LAST_X) && (y == LAST_Y);

	//////////////////////////////////////////////////////////////////////
	// blocks

	screen_mode_ctrl u_mode (
		.clk            (clk),
		.rst            (rst),
		.button_display (button_display),
		.mode           (mode)
	);

	alien_formation u_aliens (
		.clk       (clk),
		.rst       (rst),
		.mode      (mode),
		.frame_end (frame_end),
		.x         (x),
		.y         (y),
		.on_alien  (on_alien)
	);

	spaceship_ctrl u_ship (
		.clk          (clk),
		.rst          (rst),
		.mode         (mode),
		.frame_end    (frame_end),
		.button_left  (button_left),
		.button_right (button_right),
		.x            (x),
		.y            (y),
		.on_ship      (on_ship)
	);

	pixel_compositor u_comp (
		.clk      (clk),
		.rst      (rst),
		.mode     (mode),
		.x        (x),
		.y        (y),
		.on_alien (on_alien),
		.on_ship  (on_ship),
		.rgb      (rgb)
	);

endmodule

/* verilog/invaders_pkg.sv */
package invaders_pkg;

	//////////////////////////////////////////////////////////////////////
	// pixel coordinate, wide enough for the full 640x480 timing range
	typedef logic [10:0] coord_t;

	// one pixel colour
	// bits 7:6 blue, 5:3 green, 2:0 red
	typedef logic [7:0] color_t;

	//////////////////////////////////////////////////////////////////////
	// screen modes, advanced by the display button
	// black -> start -> game -> black
	typedef enum logic [1:0] {
		mode_black = 2'd0,
		mode_start = 2'd1,
		mode_game  = 2'd2
	} screen_mode_e;

endpackage

/* verilog/pixel_compositor.sv */
`include "invaders_cfg.svh"

module pixel_compositor (
	input  logic                       clk,
	input  logic                       rst,
	input  invaders_pkg::screen_mode_e mode,
	input  invaders_pkg::coord_t       x,
	input  invaders_pkg::coord_t       y,
	input  logic                       on_alien,
	input  logic                       on_ship,
	output invaders_pkg::color_t       rgb
);
	import invaders_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// rows and colours
	localparam coord_t SCREEN_W = coord_t'(`SCREEN_W);
	localparam coord_t SCREEN_H = coord_t'(`SCREEN_H);
	localparam coord_t SCORE_TOP = coord_t'(`SCOREBOARD_TOP);
	localparam coord_t SCORE_BOTTOM = coord_t'(`SCOREBOARD_BOTTOM);
	localparam coord_t BARRIER_TOP = coord_t'(`BARRIER_TOP);
	localparam coord_t BARRIER_BOTTOM = coord_t'(`BARRIER_BOTTOM);
	localparam coord_t LIVES_TOP = coord_t'(`EXTRA_LIVES_TOP);
	localparam coord_t BANNER_TOP = coord_t'(`BANNER_TOP);
	localparam coord_t BANNER_BOTTOM = coord_t'(`BANNER_BOTTOM);

	localparam color_t C_SPACE = `COLOR_SPACE;
	localparam color_t C_BANNER = `COLOR_BANNER;
	localparam color_t C_SHIP = `COLOR_SHIP;
	localparam color_t C_ALIEN = `COLOR_ALIEN;
	localparam color_t C_RED = `COLOR_RED;
	localparam color_t C_BLUE = `COLOR_BLUE;
	localparam color_t C_GREEN = `COLOR_GREEN;

	logic   visible;
	color_t game_color;
	color_t next_color;

	assign visible = (x < SCREEN_W) && (y < SCREEN_H);

	// game screen, first match wins
	always_comb begin
		if (y == SCORE_TOP || y == SCORE_BOTTOM) begin
			game_color = C_RED;
		end else if (y == BARRIER_TOP || y == BARRIER_BOTTOM) begin
			game_color = C_BLUE;
		end else if (y == LIVES_TOP) begin
			game_color = C_GREEN;
		end else if (on_ship) begin
			game_color = C_SHIP;
		end else if (on_alien) begin
			game_color = C_ALIEN;
		end else begin
			game_color = C_SPACE;
		end
	end

	always_comb begin
		next_color = C_SPACE;
		if (visible) begin
			case (mode)
				mode_start: begin
					if (y >= BANNER_TOP && y < BANNER_BOTTOM) begin
						next_color = C_BANNER;
					end
				end
				mode_game: next_color = game_color;
				default:   next_color = C_SPACE;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// output register, one cycle behind the pixel
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rgb <= C_SPACE;
		end else begin
			rgb <= next_color;
		end
	end

endmodule

/* verilog/screen_mode_ctrl.sv */
`include "invaders_cfg.svh"

module screen_mode_ctrl (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       button_display,
	output invaders_pkg::screen_mode_e mode
);
	import invaders_pkg::*;

	// last sample of the button
	logic button_q;
	logic press;

	// rising edge only so a held button advances once
	assign press = button_display & ~button_q;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			button_q <= 1'b0;
			mode <= mode_black;
		end else begin
			button_q <= button_display;
			if (press) begin
				case (mode)
					mode_black: mode <= mode_start;
					mode_start: mode <= mode_game;
					default:    mode <= mode_black;
				endcase
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// checks

	a_mode_legal: assert property (@(posedge clk) disable iff (rst)
		mode inside {mode_black, mode_start, mode_game});

endmodule

/* verilog/spaceship_ctrl.sv */
`include "invaders_cfg.svh"

module spaceship_ctrl (
	input  logic                       clk,
	input  logic                       rst,
	input  invaders_pkg::screen_mode_e mode,
	input  logic                       frame_end,
	input  logic                       button_left,
	input  logic                       button_right,
	input  invaders_pkg::coord_t       x,
	input  invaders_pkg::coord_t       y,
	output logic                       on_ship
);
	import invaders_pkg::*;

	localparam coord_t START_X = coord_t'(`SHIP_START_X);
	localparam coord_t STEP = coord_t'(`SHIP_STEP);
	localparam coord_t SHIP_W = coord_t'(`SHIP_W);
	localparam coord_t SHIP_TOP = coord_t'(`SHIP_Y);
	localparam coord_t SHIP_BOTTOM = coord_t'(`SHIP_Y + `SHIP_H);
	// rightmost legal position
	localparam coord_t MAX_X = coord_t'(`SCREEN_W - `SHIP_W);

	coord_t ship_x;
	logic   step;

	// one step per frame and both buttons cancel out
	assign step = frame_end && (mode == mode_game) && (button_left != button_right);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ship_x <= START_X;
		end else if (step) begin
			if (button_right) begin
				ship_x <= (ship_x > MAX_X - STEP) ? MAX_X : ship_x + STEP;
			end else begin
				ship_x <= (ship_x < STEP) ? '0 : ship_x - STEP;
			end
		end
	end

	assign on_ship = (x >= ship_x) && (x < ship_x + SHIP_W) &&
		(y >= SHIP_TOP) && (y < SHIP_BOTTOM);

	//////////////////////////////////////////////////////////////////////
	// checks

	a_ship_in_range: assert property (@(posedge clk) disable iff (rst)
		ship_x <= MAX_X);

endmodule
